/* Makefile */
SIM  := obj_dir/Vtb_jtlb
SRCS := $(wildcard logic/*.sv tb/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_jtlb -f build.f

run: $(SIM)
	$(SIM) | awk '{ print } /^Test completed successfully$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* build.f */
logic/jtlb_pkg.sv
logic/jtlb_gated_clk.sv
logic/jtlb_spsram.sv
logic/jtlb_data_array.sv
logic/jtlb_tag_array.sv
logic/jtlb_index_cnt.sv
logic/jtlb_ctrl_fsm.sv
logic/jtlb_top.sv
tb/tb_jtlb_checker.sv
tb/tb_jtlb.sv

/* logic/jtlb_ctrl_fsm.sv */
`timescale 1ns/1ps
// TLB operation FSM with tag compare, array control
// and response generation
module jtlb_ctrl_fsm (
  input  logic                 forever_cpuclk,
  input  logic                 rst_n,
  // Request side
  input  logic                 req_vld,
  input  jtlb_pkg::jtlb_op_t   req_op,
  input  jtlb_pkg::jtlb_vpn_t  req_vpn,
  input  jtlb_pkg::jtlb_data_t req_data,
  output logic                 busy,
  output logic                 resp_vld,
  output logic                 resp_hit,
  output logic                 resp_way,
  output jtlb_pkg::jtlb_data_t resp_data,
  // Tag array
  output logic                 tag_cen,
  output logic [1:0]           tag_wen,
  output logic                 tag_clr,
  output jtlb_pkg::jtlb_idx_t  tag_idx,
  output jtlb_pkg::jtlb_tag_t  tag_din,
  input  jtlb_pkg::jtlb_tag_t  tag_dout0,
  input  jtlb_pkg::jtlb_tag_t  tag_dout1,
  input  logic                 vld0,
  input  logic                 vld1,
  // Data array
  output logic                 data_cen0,
  output logic                 data_cen1,
  output logic [3:0]           data_wen,
  output jtlb_pkg::jtlb_idx_t  data_idx,
  output jtlb_pkg::jtlb_data_t data_din,
  input  jtlb_pkg::jtlb_data_t data_dout0,
  input  jtlb_pkg::jtlb_data_t data_dout1,
  // Index counter
  output logic                 flush_start,
  output logic                 refill_done,
  input  jtlb_pkg::jtlb_idx_t  flush_idx,
  input  logic                 flush_last,
  input  logic                 victim_way
);

  jtlb_pkg::jtlb_state_t state;
  jtlb_pkg::jtlb_state_t state_nxt;
  jtlb_pkg::jtlb_op_t    op_q;
  jtlb_pkg::jtlb_vpn_t   vpn_q;
  jtlb_pkg::jtlb_data_t  data_q;
  jtlb_pkg::jtlb_half_t  hit_lo_q;
  logic                  hit_way_q;
  logic                  req_accept;
  logic                  is_refill;
  logic                  is_update;
  logic                  hit0;
  logic                  hit1;
  logic                  hit;
  logic                  wr_way;
  logic [1:0]            half_wen;

  //============================================================
  // Request capture and state
  //============================================================
  assign busy       = (state != jtlb_pkg::ST_IDLE);
  assign req_accept = req_vld && !busy;
  assign is_refill  = (op_q == jtlb_pkg::OP_REFILL);
  assign is_update  = (op_q == jtlb_pkg::OP_UPDATE);

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      state <= jtlb_pkg::ST_IDLE;
      op_q  <= jtlb_pkg::OP_LOOKUP;
    end else begin
      state <= state_nxt;
      if (req_accept) begin
        op_q <= req_op;
      end
    end
  end

  // Request payload
  always_ff @(posedge forever_cpuclk) begin
    if (req_accept) begin
      vpn_q  <= req_vpn;
      data_q <= req_data;
    end
  end

  // Hit way and its PPN half, kept for the update write cycle
  always_ff @(posedge forever_cpuclk) begin
    if (state == jtlb_pkg::ST_CMP) begin
      hit_way_q <= !hit0;
      hit_lo_q  <= hit0 ? data_dout0[jtlb_pkg::HALF_W-1:0]
                        : data_dout1[jtlb_pkg::HALF_W-1:0];
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      jtlb_pkg::ST_IDLE: begin
        if (req_accept) begin
          case (req_op)
            jtlb_pkg::OP_REFILL: state_nxt = jtlb_pkg::ST_WRITE;
            jtlb_pkg::OP_FLUSH:  state_nxt = jtlb_pkg::ST_FLUSH;
            default:             state_nxt = jtlb_pkg::ST_READ;
          endcase
        end
      end
      jtlb_pkg::ST_READ:  state_nxt = jtlb_pkg::ST_CMP;
      // Only an update that hits goes on to write
      jtlb_pkg::ST_CMP:   state_nxt = (is_update && hit) ? jtlb_pkg::ST_WRITE
                                                         : jtlb_pkg::ST_IDLE;
      jtlb_pkg::ST_WRITE: state_nxt = jtlb_pkg::ST_IDLE;
      jtlb_pkg::ST_FLUSH: begin
        if (flush_last) begin
          state_nxt = jtlb_pkg::ST_IDLE;
        end
      end
      default:            state_nxt = jtlb_pkg::ST_IDLE;
    endcase
  end

  //============================================================
  // Tag compare
  //============================================================
  // Way 0 wins when both ways match
  assign hit0 = vld0 && (tag_dout0 == vpn_q[jtlb_pkg::VPN_W-1:jtlb_pkg::IDX_W]);
  assign hit1 = vld1 && (tag_dout1 == vpn_q[jtlb_pkg::VPN_W-1:jtlb_pkg::IDX_W]);
  assign hit  = hit0 | hit1;

  //============================================================
  // Array and counter control
  //============================================================
  // Refill targets the victim, update the way that hit
  assign wr_way   = is_refill ? victim_way : hit_way_q;
  assign half_wen = is_refill ? 2'b11 : 2'b10;

  assign tag_cen  = (state == jtlb_pkg::ST_READ) ||
                    ((state == jtlb_pkg::ST_WRITE) && is_refill);
  assign tag_wen  = ((state == jtlb_pkg::ST_WRITE) && is_refill) ?
                    {victim_way, !victim_way} : 2'b00;
  assign tag_clr  = (state == jtlb_pkg::ST_FLUSH);
  // Sweep index replaces the request index during flush
  assign tag_idx  = tag_clr ? flush_idx : vpn_q[jtlb_pkg::IDX_W-1:0];
  assign tag_din  = vpn_q[jtlb_pkg::VPN_W-1:jtlb_pkg::IDX_W];

  assign data_cen0 = (state == jtlb_pkg::ST_READ) ||
                     ((state == jtlb_pkg::ST_WRITE) && !wr_way);
  assign data_cen1 = (state == jtlb_pkg::ST_READ) ||
                     ((state == jtlb_pkg::ST_WRITE) && wr_way);
  assign data_wen  = (state != jtlb_pkg::ST_WRITE) ? 4'b0000 :
                     wr_way ? {half_wen, 2'b00} : {2'b00, half_wen};
  assign data_idx  = vpn_q[jtlb_pkg::IDX_W-1:0];
  assign data_din  = data_q;

  assign flush_start = req_accept && (req_op == jtlb_pkg::OP_FLUSH);
  assign refill_done = (state == jtlb_pkg::ST_WRITE) && is_refill;

  //============================================================
  // Response
  //============================================================
  always_comb begin
    resp_vld  = 1'b0;
    resp_hit  = 1'b0;
    resp_way  = 1'b0;
    resp_data = '0;
    case (state)
      jtlb_pkg::ST_CMP: begin
        // Update hit answers one cycle later, after its write
        resp_vld = !(is_update && hit);
        if (!is_update && hit) begin
          resp_hit  = 1'b1;
          resp_way  = !hit0;
          resp_data = hit0 ? data_dout0 : data_dout1;
        end
      end
      jtlb_pkg::ST_WRITE: begin
        resp_vld = 1'b1;
        resp_way = wr_way;
        // Entry as it now stands: new attributes, old PPN
        if (is_update) begin
          resp_hit  = 1'b1;
          resp_data = {data_q[jtlb_pkg::DATA_W-1:jtlb_pkg::HALF_W], hit_lo_q};
        end
      end
      jtlb_pkg::ST_FLUSH: resp_vld = flush_last;
      default: ;
    endcase
  end

  a_no_req_busy: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n) busy |-> !req_vld)
    else $error("jtlb_ctrl_fsm: request raised while busy");
  a_hit_vld: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n) resp_hit |-> resp_vld)
    else $error("jtlb_ctrl_fsm: hit without response valid");

endmodule

/* logic/jtlb_data_array.sv */
`timescale 1ns/1ps
// Two-bank TLB data array, one bank per way,
// with a gated clock and half-granular write masks
module jtlb_data_array #(
  parameter int NUM_SETS = 256
) (
  input  logic                 forever_cpuclk,
  input  logic                 icg_en,
  input  logic                 data_cen0,
  input  logic                 data_cen1,
  input  logic [3:0]           data_wen,
  input  jtlb_pkg::jtlb_idx_t  data_idx,
  input  jtlb_pkg::jtlb_data_t data_din,
  output jtlb_pkg::jtlb_data_t data_dout0,
  output jtlb_pkg::jtlb_data_t data_dout1
);

  localparam int AW = $clog2(NUM_SETS);

  logic                 data_clk;
  logic                 data_clk_en;
  logic [AW-1:0]        addr;
  logic                 gwen0_b;
  logic                 gwen1_b;
  jtlb_pkg::jtlb_data_t bwen0_b;
  jtlb_pkg::jtlb_data_t bwen1_b;

  //============================================================
  // Clock gate
  //============================================================
  // Either bank active wakes the clock
  assign data_clk_en = data_cen0 | data_cen1;

  jtlb_gated_clk x_data_gateclk (
    .clk_in    (forever_cpuclk),
    .local_en  (data_clk_en),
    .module_en (icg_en),
    .clk_out   (data_clk)
  );

  //============================================================
  // Write enable expansion
  //============================================================
  // Bits 2w and 2w+1 are the low and high half of way w
  assign gwen0_b = !(|data_wen[1:0]);
  assign gwen1_b = !(|data_wen[3:2]);
  assign bwen0_b = ~{{jtlb_pkg::HALF_W{data_wen[1]}}, {jtlb_pkg::HALF_W{data_wen[0]}}};
  assign bwen1_b = ~{{jtlb_pkg::HALF_W{data_wen[3]}}, {jtlb_pkg::HALF_W{data_wen[2]}}};

  assign addr = data_idx[AW-1:0];

  // Way 0 bank
  jtlb_spsram #(.NUM_SETS(NUM_SETS), .WIDTH(jtlb_pkg::DATA_W)) x_data_bank0 (
    .clk    (data_clk),
    .cen_b  (!data_cen0),
    .gwen_b (gwen0_b),
    .wen_b  (bwen0_b),
    .addr   (addr),
    .din    (data_din),
    .dout   (data_dout0)
  );

  // Way 1 bank
  jtlb_spsram #(.NUM_SETS(NUM_SETS), .WIDTH(jtlb_pkg::DATA_W)) x_data_bank1 (
    .clk    (data_clk),
    .cen_b  (!data_cen1),
    .gwen_b (gwen1_b),
    .wen_b  (bwen1_b),
    .addr   (addr),
    .din    (data_din),
    .dout   (data_dout1)
  );

  // Write to a bank the FSM left disabled would be lost
  a_wen0_cen: assert property (@(posedge forever_cpuclk) |data_wen[1:0] |-> data_cen0)
    else $error("jtlb_data_array: way 0 write without chip enable");
  a_wen1_cen: assert property (@(posedge forever_cpuclk) |data_wen[3:2] |-> data_cen1)
    else $error("jtlb_data_array: way 1 write without chip enable");

endmodule

/* logic/jtlb_gated_clk.sv */
`timescale 1ns/1ps
// Latch-based clock gate with local and module enables
module jtlb_gated_clk (
  input  logic clk_in,
  input  logic local_en,
  input  logic module_en,
  output logic clk_out
);

  logic en_any;
  logic en_lat;

  // Module enable keeps the clock free running
  assign en_any = local_en | module_en;

  // Transparent in the low phase
  // so the enable cannot glitch a high pulse
  always_latch begin
    if (!clk_in) begin
      en_lat <= en_any;
    end
  end

  assign clk_out = clk_in & en_lat;

endmodule

/* logic/jtlb_index_cnt.sv */
`timescale 1ns/1ps
// Flush sweep index counter and round-robin refill victim pointer
module jtlb_index_cnt #(
  parameter int NUM_SETS = 256
) (
  input  logic                forever_cpuclk,
  input  logic                rst_n,
  input  logic                flush_start,
  input  logic                refill_done,
  output jtlb_pkg::jtlb_idx_t flush_idx,
  output logic                flush_last,
  output logic                victim_way
);

  localparam jtlb_pkg::jtlb_idx_t LAST_IDX = jtlb_pkg::jtlb_idx_t'(NUM_SETS - 1);

  logic flush_act;

  // Final set of the sweep
  assign flush_last = flush_act && (flush_idx == LAST_IDX);

  // Sweep starts at set 0 in the cycle after the start strobe
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      flush_act <= 1'b0;
      flush_idx <= '0;
    end else if (flush_start) begin
      flush_act <= 1'b1;
      flush_idx <= '0;
    end else if (flush_act) begin
      flush_idx <= flush_idx + 1'b1;
      if (flush_last) begin
        flush_act <= 1'b0;
      end
    end
  end

  // One pointer for all sets, toggled per refill
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      victim_way <= 1'b0;
    end else if (refill_done) begin
      victim_way <= !victim_way;
    end
  end

  // FSM must not restart a sweep that is still running
  a_no_restart: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n) flush_act |-> !flush_start)
    else $error("jtlb_index_cnt: flush restarted mid sweep");

endmodule

/* logic/jtlb_pkg.sv */
// Shared widths, vector typedefs, operation codes and FSM states
// for the joint TLB storage subsystem
package jtlb_pkg;

  //============================================================
  // Field widths
  //============================================================
  // Set index is the low part of the VPN, tag the rest
  localparam int IDX_W  = 8;
  localparam int TAG_W  = 19;
  localparam int VPN_W  = IDX_W + TAG_W;
  // Low half carries the PPN, high half the attributes
  localparam int HALF_W = 42;
  localparam int DATA_W = 2 * HALF_W;

  typedef logic [VPN_W-1:0]  jtlb_vpn_t;
  typedef logic [IDX_W-1:0]  jtlb_idx_t;
  typedef logic [TAG_W-1:0]  jtlb_tag_t;
  typedef logic [HALF_W-1:0] jtlb_half_t;
  typedef logic [DATA_W-1:0] jtlb_data_t;

  //============================================================
  // Operations and FSM states
  //============================================================
  typedef enum logic [1:0] {
    OP_LOOKUP = 2'd0,
    OP_REFILL = 2'd1,
    OP_UPDATE = 2'd2,
    OP_FLUSH  = 2'd3
  } jtlb_op_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,
    ST_CMP,
    ST_WRITE,
    ST_FLUSH
  } jtlb_state_t;

endpackage

/* logic/jtlb_spsram.sv */
`timescale 1ns/1ps
// Behavioral single-port SRAM with active-low chip enable,
// global write enable and per-bit write mask
module jtlb_spsram #(
  parameter int NUM_SETS = 256,
  parameter int WIDTH    = 84
) (
  input  logic                        clk,
  input  logic                        cen_b,
  input  logic                        gwen_b,
  input  logic [WIDTH-1:0]            wen_b,
  input  logic [$clog2(NUM_SETS)-1:0] addr,
  input  logic [WIDTH-1:0]            din,
  output logic [WIDTH-1:0]            dout
);

  logic [WIDTH-1:0] mem [NUM_SETS];

  // Write merges masked bits, read registers the word
  // Output holds on writes and idle cycles
  always_ff @(posedge clk) begin
    if (!cen_b) begin
      if (!gwen_b) begin
        // Low mask bit selects din
        mem[addr] <= (mem[addr] & wen_b) | (din & ~wen_b);
      end else begin
        dout <= mem[addr];
      end
    end
  end

  // Selected macro needs a clean address
  a_addr_known: assert property (@(posedge clk) !cen_b |-> !$isunknown(addr))
    else $error("jtlb_spsram: unknown address with chip enable active");

endmodule

/* logic/jtlb_tag_array.sv */
`timescale 1ns/1ps
// Two-way tag SRAM with valid bits held in flops
// so that reset and flush can clear them
module jtlb_tag_array #(
  parameter int NUM_SETS = 256
) (
  input  logic                forever_cpuclk,
  input  logic                rst_n,
  input  logic                tag_cen,
  input  logic [1:0]          tag_wen,
  input  logic                tag_clr,
  input  jtlb_pkg::jtlb_idx_t tag_idx,
  input  jtlb_pkg::jtlb_tag_t tag_din,
  output jtlb_pkg::jtlb_tag_t tag_dout0,
  output jtlb_pkg::jtlb_tag_t tag_dout1,
  output logic                vld0,
  output logic                vld1
);

  localparam int AW = $clog2(NUM_SETS);

  logic [AW-1:0]       addr;
  logic [NUM_SETS-1:0] vld_arr0;
  logic [NUM_SETS-1:0] vld_arr1;

  assign addr = tag_idx[AW-1:0];

  // Tags are always written whole
  jtlb_spsram #(.NUM_SETS(NUM_SETS), .WIDTH(jtlb_pkg::TAG_W)) x_tag_bank0 (
    .clk    (forever_cpuclk),
    .cen_b  (!tag_cen),
    .gwen_b (!tag_wen[0]),
    .wen_b  ('0),
    .addr   (addr),
    .din    (tag_din),
    .dout   (tag_dout0)
  );

  jtlb_spsram #(.NUM_SETS(NUM_SETS), .WIDTH(jtlb_pkg::TAG_W)) x_tag_bank1 (
    .clk    (forever_cpuclk),
    .cen_b  (!tag_cen),
    .gwen_b (!tag_wen[1]),
    .wen_b  ('0),
    .addr   (addr),
    .din    (tag_din),
    .dout   (tag_dout1)
  );

  //============================================================
  // Valid bits
  //============================================================
  // Flush clear wins over a write to the same set
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      vld_arr0 <= '0;
      vld_arr1 <= '0;
    end else if (tag_clr) begin
      vld_arr0[addr] <= 1'b0;
      vld_arr1[addr] <= 1'b0;
    end else if (tag_cen) begin
      if (tag_wen[0]) begin
        vld_arr0[addr] <= 1'b1;
      end
      if (tag_wen[1]) begin
        vld_arr1[addr] <= 1'b1;
      end
    end
  end

  // Valid read lines up with the bank read
  always_ff @(posedge forever_cpuclk) begin
    if (tag_cen && !tag_wen[0]) begin
      vld0 <= vld_arr0[addr];
    end
    if (tag_cen && !tag_wen[1]) begin
      vld1 <= vld_arr1[addr];
    end
  end

endmodule

/* logic/jtlb_top.sv */
`timescale 1ns/1ps
// Joint TLB storage subsystem top, FSM, counter,
// tag array and data array wired together
module jtlb_top #(
  parameter int NUM_SETS = 256
) (
  input  logic                 forever_cpuclk,
  input  logic                 rst_n,
  input  logic                 req_vld,
  input  jtlb_pkg::jtlb_op_t   req_op,
  input  jtlb_pkg::jtlb_vpn_t  req_vpn,
  input  jtlb_pkg::jtlb_data_t req_data,
  input  logic                 icg_en,
  output logic                 busy,
  output logic                 resp_vld,
  output logic                 resp_hit,
  output logic                 resp_way,
  output jtlb_pkg::jtlb_data_t resp_data
);

  logic                 tag_cen;
  logic [1:0]           tag_wen;
  logic                 tag_clr;
  jtlb_pkg::jtlb_idx_t  tag_idx;
  jtlb_pkg::jtlb_tag_t  tag_din;
  jtlb_pkg::jtlb_tag_t  tag_dout0;
  jtlb_pkg::jtlb_tag_t  tag_dout1;
  logic                 vld0;
  logic                 vld1;
  logic                 data_cen0;
  logic                 data_cen1;
  logic [3:0]           data_wen;
  jtlb_pkg::jtlb_idx_t  data_idx;
  jtlb_pkg::jtlb_data_t data_din;
  jtlb_pkg::jtlb_data_t data_dout0;
  jtlb_pkg::jtlb_data_t data_dout1;
  logic                 flush_start;
  logic                 refill_done;
  jtlb_pkg::jtlb_idx_t  flush_idx;
  logic                 flush_last;
  logic                 victim_way;

  jtlb_ctrl_fsm x_ctrl_fsm (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .req_vld        (req_vld),
    .req_op         (req_op),
    .req_vpn        (req_vpn),
    .req_data       (req_data),
    .busy           (busy),
    .resp_vld       (resp_vld),
    .resp_hit       (resp_hit),
    .resp_way       (resp_way),
    .resp_data      (resp_data),
    .tag_cen        (tag_cen),
    .tag_wen        (tag_wen),
    .tag_clr        (tag_clr),
    .tag_idx        (tag_idx),
    .tag_din        (tag_din),
    .tag_dout0      (tag_dout0),
    .tag_dout1      (tag_dout1),
    .vld0           (vld0),
    .vld1           (vld1),
    .data_cen0      (data_cen0),
    .data_cen1      (data_cen1),
    .data_wen       (data_wen),
    .data_idx       (data_idx),
    .data_din       (data_din),
    .data_dout0     (data_dout0),
    .data_dout1     (data_dout1),
    .flush_start    (flush_start),
    .refill_done    (refill_done),
    .flush_idx      (flush_idx),
    .flush_last     (flush_last),
    .victim_way     (victim_way)
  );

  jtlb_index_cnt #(.NUM_SETS(NUM_SETS)) x_index_cnt (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .flush_start    (flush_start),
    .refill_done    (refill_done),
    .flush_idx      (flush_idx),
    .flush_last     (flush_last),
    .victim_way     (victim_way)
  );

  jtlb_tag_array #(.NUM_SETS(NUM_SETS)) x_tag_array (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .tag_cen        (tag_cen),
    .tag_wen        (tag_wen),
    .tag_clr        (tag_clr),
    .tag_idx        (tag_idx),
    .tag_din        (tag_din),
    .tag_dout0      (tag_dout0),
    .tag_dout1      (tag_dout1),
    .vld0           (vld0),
    .vld1           (vld1)
  );

  jtlb_data_array #(.NUM_SETS(NUM_SETS)) x_data_array (
    .forever_cpuclk (forever_cpuclk),
    .icg_en         (icg_en),
    .data_cen0      (data_cen0),
    .data_cen1      (data_cen1),
    .data_wen       (data_wen),
    .data_idx       (data_idx),
    .data_din       (data_din),
    .data_dout0     (data_dout0),
    .data_dout1     (data_dout1)
  );

endmodule

/* tb/tb_jtlb.sv */
`timescale 1ns/1ps
// Joint TLB testbench top with clock, reset, xorshift stimulus,
// reference model of the two-way TLB and run timeout
module tb_jtlb;

  localparam int NUM_SETS = 256;
  localparam int NUM_OPS  = 400;
  localparam int RAND_OPS = 360;
  localparam int LIMIT    = NUM_OPS * 300;

  logic                 clk;
  logic                 rst_n;
  logic                 req_vld;
  jtlb_pkg::jtlb_op_t   req_op;
  jtlb_pkg::jtlb_vpn_t  req_vpn;
  jtlb_pkg::jtlb_data_t req_data;
  logic                 icg_en;
  logic                 busy;
  logic                 resp_vld;
  logic                 resp_hit;
  logic                 resp_way;
  jtlb_pkg::jtlb_data_t resp_data;
  logic                 exp_hit;
  logic                 exp_way;
  logic                 exp_way_chk;
  jtlb_pkg::jtlb_data_t exp_data;
  int                   exp_lat;
  int                   mismatch_cnt;
  int                   other_cnt;
  int                   resp_cnt;
  int                   cycle_cnt;
  logic [31:0]          rng = 32'h33a00e51;

  // Model state with one entry per way and set
  logic                 m_vld  [2][NUM_SETS];
  jtlb_pkg::jtlb_tag_t  m_tag  [2][NUM_SETS];
  jtlb_pkg::jtlb_data_t m_data [2][NUM_SETS];
  logic                 m_victim;
  // Recently refilled VPNs are reused to get hits
  jtlb_pkg::jtlb_vpn_t  pool[$];

  jtlb_top #(.NUM_SETS(NUM_SETS)) i_dut (
    .forever_cpuclk (clk),
    .rst_n          (rst_n),
    .req_vld        (req_vld),
    .req_op         (req_op),
    .req_vpn        (req_vpn),
    .req_data       (req_data),
    .icg_en         (icg_en),
    .busy           (busy),
    .resp_vld       (resp_vld),
    .resp_hit       (resp_hit),
    .resp_way       (resp_way),
    .resp_data      (resp_data)
  );

  tb_jtlb_checker i_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_vld      (req_vld),
    .busy         (busy),
    .resp_vld     (resp_vld),
    .resp_hit     (resp_hit),
    .resp_way     (resp_way),
    .resp_data    (resp_data),
    .exp_hit      (exp_hit),
    .exp_way      (exp_way),
    .exp_way_chk  (exp_way_chk),
    .exp_data     (exp_data),
    .exp_lat      (exp_lat),
    .mismatch_cnt (mismatch_cnt),
    .other_cnt    (other_cnt),
    .resp_cnt     (resp_cnt)
  );

  always #10 clk = ~clk;

  //============================================================
  // Random sources
  //============================================================
  function logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function jtlb_pkg::jtlb_vpn_t random_vpn();
    logic [31:0] r;
    r = next_rand();
    return r[jtlb_pkg::VPN_W-1:0];
  endfunction

  // Few sets and few tags make ways collide often
  function jtlb_pkg::jtlb_vpn_t clustered_vpn();
    logic [31:0] r;
    r = next_rand();
    return jtlb_pkg::jtlb_vpn_t'({r[3:0], 5'b0, r[6:4]});
  endfunction

  function jtlb_pkg::jtlb_data_t random_data();
    logic [95:0] w;
    w = {next_rand(), next_rand(), next_rand()};
    return w[jtlb_pkg::DATA_W-1:0];
  endfunction

  function jtlb_pkg::jtlb_vpn_t pick_vpn();
    logic [31:0] r;
    r = next_rand();
    if (pool.size() > 0 && r[0]) begin
      return pool[r[15:8] % pool.size()];
    end
    return clustered_vpn();
  endfunction

  //============================================================
  // Request with model update
  //============================================================
  // Called just after a rising edge with busy low
  task automatic issue(input jtlb_pkg::jtlb_op_t op, input jtlb_pkg::jtlb_vpn_t vpn,
                       input jtlb_pkg::jtlb_data_t data);
    jtlb_pkg::jtlb_idx_t  idx;
    jtlb_pkg::jtlb_tag_t  tag;
    logic                 hit0;
    logic                 hit1;
    logic                 way;
    logic                 e_hit;
    logic                 e_chk;
    jtlb_pkg::jtlb_data_t e_data;
    int                   e_lat;
    int                   cnt0;
    idx    = vpn[jtlb_pkg::IDX_W-1:0];
    tag    = vpn[jtlb_pkg::VPN_W-1:jtlb_pkg::IDX_W];
    hit0   = m_vld[0][idx] && (m_tag[0][idx] == tag);
    hit1   = m_vld[1][idx] && (m_tag[1][idx] == tag);
    way    = !hit0;
    e_hit  = 1'b0;
    e_chk  = 1'b0;
    e_data = '0;
    e_lat  = 2;
    case (op)
      jtlb_pkg::OP_LOOKUP: begin
        e_hit = hit0 | hit1;
        e_chk = e_hit;
        if (e_hit) begin
          e_data = m_data[way][idx];
        end
      end
      jtlb_pkg::OP_UPDATE: begin
        // Only the attribute half changes
        if (hit0 | hit1) begin
          m_data[way][idx][jtlb_pkg::DATA_W-1:jtlb_pkg::HALF_W] =
            data[jtlb_pkg::DATA_W-1:jtlb_pkg::HALF_W];
          e_hit  = 1'b1;
          e_chk  = 1'b1;
          e_data = m_data[way][idx];
          e_lat  = 3;
        end
      end
      jtlb_pkg::OP_REFILL: begin
        way                = m_victim;
        m_vld[way][idx]    = 1'b1;
        m_tag[way][idx]    = tag;
        m_data[way][idx]   = data;
        m_victim           = !m_victim;
        e_chk              = 1'b1;
        e_lat              = 1;
        if (pool.size() >= 32) begin
          void'(pool.pop_front());
        end
        pool.push_back(vpn);
      end
      default: begin
        for (int s = 0; s < NUM_SETS; s++) begin
          m_vld[0][s] = 1'b0;
          m_vld[1][s] = 1'b0;
        end
        e_lat = NUM_SETS;
      end
    endcase
    cnt0        = resp_cnt;
    req_vld     <= 1'b1;
    req_op      <= op;
    req_vpn     <= vpn;
    req_data    <= data;
    exp_hit     <= e_hit;
    exp_way     <= way;
    exp_way_chk <= e_chk;
    exp_data    <= e_data;
    exp_lat     <= e_lat;
    @(posedge clk);
    req_vld <= 1'b0;
    while (resp_cnt == cnt0) begin
      @(posedge clk);
    end
  endtask

  task automatic print_counts();
    $display("Error counts: %0d mismatches, %0d other errors, %0d responses checked",
             mismatch_cnt, other_cnt, resp_cnt);
  endtask

  //============================================================
  // Timeout
  //============================================================
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("Timeout after %0d cycles, a response never arrived", cycle_cnt);
      print_counts();
      $display("Test failed");
      $finish;
    end
  end

  //============================================================
  // Test sequence
  //============================================================
  initial begin
    jtlb_pkg::jtlb_vpn_t va;
    jtlb_pkg::jtlb_vpn_t vb;
    jtlb_pkg::jtlb_vpn_t vc [3];
    jtlb_pkg::jtlb_op_t  op;
    logic [31:0]         r;
    int                  n;
    clk         = 1'b0;
    rst_n       = 1'b0;
    req_vld     = 1'b0;
    req_op      = jtlb_pkg::OP_LOOKUP;
    req_vpn     = '0;
    req_data    = '0;
    icg_en      = 1'b0;
    exp_hit     = 1'b0;
    exp_way     = 1'b0;
    exp_way_chk = 1'b0;
    exp_data    = '0;
    exp_lat     = 0;
    cycle_cnt   = 0;
    m_victim    = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_vld[0][s] = 1'b0;
      m_vld[1][s] = 1'b0;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Empty TLB misses everywhere
    repeat (8) issue(jtlb_pkg::OP_LOOKUP, random_vpn(), random_data());

    // Refill then lookup with alternating ways
    va = random_vpn();
    vb = random_vpn();
    issue(jtlb_pkg::OP_REFILL, va, random_data());
    issue(jtlb_pkg::OP_REFILL, vb, random_data());
    issue(jtlb_pkg::OP_LOOKUP, va, random_data());
    issue(jtlb_pkg::OP_LOOKUP, vb, random_data());

    // Update on a hit and then on a miss in the same set
    issue(jtlb_pkg::OP_UPDATE, va, random_data());
    issue(jtlb_pkg::OP_LOOKUP, va, random_data());
    issue(jtlb_pkg::OP_UPDATE, va ^ jtlb_pkg::jtlb_vpn_t'(1 << jtlb_pkg::IDX_W),
          random_data());
    issue(jtlb_pkg::OP_LOOKUP, va, random_data());

    // Third tag into one set evicts the older way
    r = next_rand();
    for (int k = 0; k < 3; k++) begin
      vc[k] = {jtlb_pkg::jtlb_tag_t'(r[31:13] + k), r[7:0]};
      issue(jtlb_pkg::OP_REFILL, vc[k], random_data());
    end
    for (int k = 0; k < 3; k++) begin
      issue(jtlb_pkg::OP_LOOKUP, vc[k], random_data());
    end

    // Flush and then every refilled VPN misses
    issue(jtlb_pkg::OP_FLUSH, '0, '0);
    for (int k = 0; k < pool.size(); k++) begin
      issue(jtlb_pkg::OP_LOOKUP, pool[k], random_data());
    end

    // Mixed traffic with the clock gate override toggling
    for (n = 0; n < RAND_OPS; n++) begin
      r = next_rand();
      icg_en <= r[8];
      if (r[3:0] == 4'd0) begin
        op = jtlb_pkg::OP_FLUSH;
      end else if (r[3:0] < 4'd6) begin
        op = jtlb_pkg::OP_REFILL;
      end else if (r[3:0] < 4'd10) begin
        op = jtlb_pkg::OP_UPDATE;
      end else begin
        op = jtlb_pkg::OP_LOOKUP;
      end
      issue(op, pick_vpn(), random_data());
    end

    repeat (3) @(posedge clk);
    print_counts();
    if (mismatch_cnt + other_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* tb/tb_jtlb_checker.sv */
`timescale 1ns/1ps
// Response checker for the joint TLB testbench
// compares every response with the expectation set by the model
module tb_jtlb_checker (
  input  logic                 clk,
  input  logic                 rst_n,
  // DUT side
  input  logic                 req_vld,
  input  logic                 busy,
  input  logic                 resp_vld,
  input  logic                 resp_hit,
  input  logic                 resp_way,
  input  jtlb_pkg::jtlb_data_t resp_data,
  // Model side held from the request until its response
  input  logic                 exp_hit,
  input  logic                 exp_way,
  input  logic                 exp_way_chk,
  input  jtlb_pkg::jtlb_data_t exp_data,
  input  int                   exp_lat,
  // Counters
  output int                   mismatch_cnt,
  output int                   other_cnt,
  output int                   resp_cnt
);

  logic pending;
  int   cyc;

  // Outputs are sampled on the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      pending      = 1'b0;
      cyc          = 0;
      mismatch_cnt = 0;
      other_cnt    = 0;
      resp_cnt     = 0;
    end else begin
      // Busy covers cycle 1 up to the response
      if (pending) begin
        cyc = cyc + 1;
        if (!busy) begin
          other_cnt = other_cnt + 1;
          $display("busy dropped before the response arrived at %0t", $time);
        end
      end else if (busy) begin
        // Nothing outstanding, also right after reset
        other_cnt = other_cnt + 1;
        $display("busy high with no request outstanding at %0t", $time);
      end
      if (resp_hit && !resp_vld) begin
        other_cnt = other_cnt + 1;
        $display("resp_hit raised without resp_vld at %0t", $time);
      end
      if (resp_vld) begin
        if (!pending) begin
          other_cnt = other_cnt + 1;
          $display("Response arrived with no request outstanding at %0t", $time);
        end else begin
          if (cyc != exp_lat) begin
            other_cnt = other_cnt + 1;
            $display("Response arrived %0d cycles after the request instead of %0d",
                     cyc, exp_lat);
          end
          if (resp_hit !== exp_hit) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch resp_hit: got 0x%h, expected 0x%h at %0t",
                     resp_hit, exp_hit, $time);
          end
          // Way only matters on a hit or a refill
          if (exp_way_chk && (resp_way !== exp_way)) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch resp_way: got 0x%h, expected 0x%h at %0t",
                     resp_way, exp_way, $time);
          end
          if (resp_data !== exp_data) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("Mismatch resp_data: got 0x%h, expected 0x%h at %0t",
                     resp_data, exp_data, $time);
          end
          pending  = 1'b0;
          resp_cnt = resp_cnt + 1;
        end
      end
      // Request cycle counts as cycle 0
      if (req_vld && !busy) begin
        pending = 1'b1;
        cyc     = 0;
      end
    end
  end

endmodule
